//--- Bender.yml
package:
  name: pcore_exe

sources:
  - pcore_pkg.sv
  - pcore_regfile.sv
  - pcore_decode.sv
  - pcore_execute.sv
  - pcore_exe_top.sv
  - target: test
    files:
      - pcore_exe_checker.sv
      - tb_pcore_exe.sv

//--- all.f
pcore_pkg.sv
pcore_regfile.sv
pcore_decode.sv
pcore_execute.sv
pcore_exe_top.sv
pcore_exe_checker.sv
tb_pcore_exe.sv

//--- pcore_decode.sv
// Decode stage: control decode, immediate build, operand forwarding and the ID/EXE register
`timescale 1ns/1ps

module pcore_decode (
   input  logic                     clk,
   input  logic                     rst_i,

   input  logic                     instr_valid_i,
   input  pcore_pkg::instr_t        instr_i,
   input  pcore_pkg::xlen_t         pc_i,

   input  pcore_pkg::xlen_t         rs1_rdata_i,
   input  pcore_pkg::xlen_t         rs2_rdata_i,
   input  logic                     ex_fwd_valid_i,
   input  pcore_pkg::reg_addr_t     ex_fwd_rd_i,
   input  pcore_pkg::xlen_t         ex_fwd_data_i,
   input  logic                     ex_redirect_i,

   output pcore_pkg::reg_addr_t     rs1_addr_o,
   output pcore_pkg::reg_addr_t     rs2_addr_o,
   output logic                     illegal_o,

   output logic                     id_valid_o,
   output pcore_pkg::xlen_t         id_pc_o,
   output pcore_pkg::xlen_t         id_rs1_data_o,
   output pcore_pkg::xlen_t         id_rs2_data_o,
   output pcore_pkg::xlen_t         id_imm_o,
   output pcore_pkg::reg_addr_t     id_rd_o,
   output pcore_pkg::alu_ops_e      id_alu_ops_o,
   output pcore_pkg::br_ops_e       id_br_ops_o,
   output pcore_pkg::opr1_sel_e     id_opr1_sel_o,
   output pcore_pkg::opr2_sel_e     id_opr2_sel_o,
   output pcore_pkg::cmp_opr2_sel_e id_cmp_opr2_sel_o,
   output pcore_pkg::wb_sel_e       id_wb_sel_o,
   output logic                     id_rd_wr_req_o,
   output logic                     id_jump_req_o,
   output logic                     id_branch_req_o
);
   import pcore_pkg::*;

   logic [6:0]    opcode;
   logic [2:0]    funct3;
   xlen_t         imm_i, imm_u, imm_b, imm_j;
   xlen_t         imm;
   xlen_t         rs1_data, rs2_data;
   alu_ops_e      alu_ops;
   br_ops_e       br_ops;
   opr1_sel_e     opr1_sel;
   opr2_sel_e     opr2_sel;
   cmp_opr2_sel_e cmp_sel;
   wb_sel_e       wb_sel;
   logic          rd_wr_req, jump_req, branch_req;
   logic          illegal;
   logic          id_valid_q;
   logic          illegal_q;

   // Shared funct3 map of OP and OP-IMM
   function automatic alu_ops_e alu_op_decode(input logic [2:0] f3, input logic alt,
                                              input logic is_reg);
      alu_ops_e op;
      case (f3)
         3'b000:  op = (alt && is_reg) ? ALU_OPS_SUB : ALU_OPS_ADD;
         3'b001:  op = ALU_OPS_SLL;
         3'b010:  op = ALU_OPS_SLT;
         3'b011:  op = ALU_OPS_SLTU;
         3'b100:  op = ALU_OPS_XOR;
         3'b101:  op = alt ? ALU_OPS_SRA : ALU_OPS_SRL;
         3'b110:  op = ALU_OPS_OR;
         default: op = ALU_OPS_AND;
      endcase
      return op;
   endfunction

   assign opcode     = instr_i[6:0];
   assign funct3     = instr_i[14:12];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   always_comb begin
      alu_ops    = ALU_OPS_NONE;
      br_ops     = BR_NONE;
      opr1_sel   = ALU_OPR1_REG;
      opr2_sel   = ALU_OPR2_IMM;
      cmp_sel    = ALU_CMP_OPR2_REG;
      wb_sel     = RD_WB_ALU;
      imm        = imm_i;
      rd_wr_req  = 1'b0;
      jump_req   = 1'b0;
      branch_req = 1'b0;
      illegal    = 1'b0;
      case (opcode)
         OPC_OP: begin
            alu_ops   = alu_op_decode(funct3, instr_i[30], 1'b1);
            opr2_sel  = ALU_OPR2_REG;
            rd_wr_req = 1'b1;
         end
         OPC_OP_IMM: begin
            alu_ops   = alu_op_decode(funct3, instr_i[30], 1'b0);
            cmp_sel   = ALU_CMP_OPR2_IMM;    // SLTI and SLTIU compare against imm
            rd_wr_req = 1'b1;
         end
         OPC_LUI: begin
            alu_ops   = ALU_OPS_COPY_OPR2;
            imm       = imm_u;
            rd_wr_req = 1'b1;
         end
         OPC_AUIPC: begin
            alu_ops   = ALU_OPS_ADD;
            opr1_sel  = ALU_OPR1_PC;
            imm       = imm_u;
            rd_wr_req = 1'b1;
         end
         OPC_BRANCH: begin
            alu_ops    = ALU_OPS_BRANCH;
            opr1_sel   = ALU_OPR1_PC;
            imm        = imm_b;
            branch_req = 1'b1;
            case (funct3)
               3'b000:  br_ops = BR_EQ;
               3'b001:  br_ops = BR_NE;
               3'b100:  br_ops = BR_LT;
               3'b101:  br_ops = BR_GE;
               3'b110:  br_ops = BR_LTU;
               3'b111:  br_ops = BR_GEU;
               default: br_ops = BR_NONE;  // Reserved encodings never taken
            endcase
         end
         OPC_JAL, OPC_JALR: begin
            alu_ops   = ALU_OPS_ADD;
            opr1_sel  = (opcode == OPC_JAL) ? ALU_OPR1_PC : ALU_OPR1_REG;
            imm       = (opcode == OPC_JAL) ? imm_j : imm_i;
            wb_sel    = RD_WB_PC_NEXT;
            rd_wr_req = 1'b1;
            jump_req  = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

   // Execute result has priority, register file covers older writes
   assign rs1_data = (ex_fwd_valid_i && ex_fwd_rd_i == rs1_addr_o && rs1_addr_o != '0)
                   ? ex_fwd_data_i : rs1_rdata_i;
   assign rs2_data = (ex_fwd_valid_i && ex_fwd_rd_i == rs2_addr_o && rs2_addr_o != '0)
                   ? ex_fwd_data_i : rs2_rdata_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         id_valid_q <= 1'b0;
         illegal_q  <= 1'b0;
         illegal_o  <= 1'b0;
      end else begin
         id_valid_q <= instr_valid_i & ~illegal;
         illegal_q  <= instr_valid_i & illegal;
         illegal_o  <= illegal_q & ~ex_redirect_i;  // Lines up with the commit register
      end
   end

   always_ff @(posedge clk) begin
      id_pc_o           <= pc_i;
      id_rs1_data_o     <= rs1_data;
      id_rs2_data_o     <= rs2_data;
      id_imm_o          <= imm;
      id_rd_o           <= instr_i[11:7];
      id_alu_ops_o      <= alu_ops;
      id_br_ops_o       <= br_ops;
      id_opr1_sel_o     <= opr1_sel;
      id_opr2_sel_o     <= opr2_sel;
      id_cmp_opr2_sel_o <= cmp_sel;
      id_wb_sel_o       <= wb_sel;
      id_rd_wr_req_o    <= rd_wr_req;
      id_jump_req_o     <= jump_req;
      id_branch_req_o   <= branch_req;
   end

   // Slot behind a taken branch or jump is dropped here
   assign id_valid_o = id_valid_q & ~ex_redirect_i;

endmodule : pcore_decode

//--- pcore_exe_checker.sv
// Concurrent assertions on the commit, redirect and illegal outputs of the pipeline top
`timescale 1ns/1ps

module pcore_exe_checker (
   input logic                 clk,
   input logic                 rst_i,
   input logic                 commit_valid_i,
   input logic                 commit_we_i,
   input pcore_pkg::reg_addr_t commit_rd_i,
   input logic                 redirect_i,
   input logic                 illegal_i
);

   int fail_count = 0;   // Count of failed assertions

   // Synchronous reset clears the status flags at the edge that samples it
   reset_clears_outputs: assert property (@(posedge clk)
      rst_i |=> (!commit_valid_i && !redirect_i && !illegal_i))
      else begin
         $error("Commit, redirect or illegal flag active during reset");
         fail_count++;
      end

   redirect_has_commit: assert property (@(posedge clk) disable iff (rst_i)
      redirect_i |-> commit_valid_i)
      else begin
         $error("Redirect without a committed instruction");
         fail_count++;
      end

   write_not_x0: assert property (@(posedge clk) disable iff (rst_i)
      commit_we_i |-> (commit_rd_i != '0))
      else begin
         $error("Register write request targets x0");
         fail_count++;
      end

   // Slot behind a taken branch or jump never commits
   squash_after_redirect: assert property (@(posedge clk) disable iff (rst_i)
      redirect_i |=> !commit_valid_i)
      else begin
         $error("Instruction committed right after a redirect");
         fail_count++;
      end

endmodule : pcore_exe_checker

bind pcore_exe_top pcore_exe_checker pcore_exe_checker_i (
   .clk            (clk),
   .rst_i          (rst_i),
   .commit_valid_i (commit_valid_o),
   .commit_we_i    (commit_we_o),
   .commit_rd_i    (commit_rd_o),
   .redirect_i     (redirect_o),
   .illegal_i      (illegal_o)
);

//--- pcore_exe_top.sv
// Pipeline top that links decode, register file and execute of the RV32I slice
`timescale 1ns/1ps

module pcore_exe_top (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 instr_valid_i,
   input  pcore_pkg::instr_t    instr_i,
   input  pcore_pkg::xlen_t     pc_i,
   output logic                 commit_valid_o,
   output pcore_pkg::xlen_t     commit_pc_o,
   output logic                 commit_we_o,
   output pcore_pkg::reg_addr_t commit_rd_o,
   output pcore_pkg::xlen_t     commit_result_o,
   output logic                 redirect_o,
   output pcore_pkg::xlen_t     redirect_pc_o,
   output logic                 illegal_o
);
   import pcore_pkg::*;

   reg_addr_t     rs1_addr, rs2_addr;
   xlen_t         rs1_rdata, rs2_rdata;

   logic          id_valid;
   xlen_t         id_pc, id_rs1_data, id_rs2_data, id_imm;
   reg_addr_t     id_rd;
   alu_ops_e      id_alu_ops;
   br_ops_e       id_br_ops;
   opr1_sel_e     id_opr1_sel;
   opr2_sel_e     id_opr2_sel;
   cmp_opr2_sel_e id_cmp_opr2_sel;
   wb_sel_e       id_wb_sel;
   logic          id_rd_wr_req, id_jump_req, id_branch_req;

   logic          ex_fwd_valid;
   reg_addr_t     ex_fwd_rd;
   xlen_t         ex_fwd_data;

   pcore_decode pcore_decode_i (
      .clk               (clk),
      .rst_i             (rst_i),
      .instr_valid_i     (instr_valid_i),
      .instr_i           (instr_i),
      .pc_i              (pc_i),
      .rs1_rdata_i       (rs1_rdata),
      .rs2_rdata_i       (rs2_rdata),
      .ex_fwd_valid_i    (ex_fwd_valid),
      .ex_fwd_rd_i       (ex_fwd_rd),
      .ex_fwd_data_i     (ex_fwd_data),
      .ex_redirect_i     (redirect_o),        // Registered redirect squashes the next slot
      .rs1_addr_o        (rs1_addr),
      .rs2_addr_o        (rs2_addr),
      .illegal_o         (illegal_o),
      .id_valid_o        (id_valid),
      .id_pc_o           (id_pc),
      .id_rs1_data_o     (id_rs1_data),
      .id_rs2_data_o     (id_rs2_data),
      .id_imm_o          (id_imm),
      .id_rd_o           (id_rd),
      .id_alu_ops_o      (id_alu_ops),
      .id_br_ops_o       (id_br_ops),
      .id_opr1_sel_o     (id_opr1_sel),
      .id_opr2_sel_o     (id_opr2_sel),
      .id_cmp_opr2_sel_o (id_cmp_opr2_sel),
      .id_wb_sel_o       (id_wb_sel),
      .id_rd_wr_req_o    (id_rd_wr_req),
      .id_jump_req_o     (id_jump_req),
      .id_branch_req_o   (id_branch_req)
   );

   // Writeback comes straight from the commit register
   pcore_regfile pcore_regfile_i (
      .clk         (clk),
      .rst_i       (rst_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rs1_rdata_o (rs1_rdata),
      .rs2_rdata_o (rs2_rdata),
      .wr_en_i     (commit_we_o),
      .wr_addr_i   (commit_rd_o),
      .wr_data_i   (commit_result_o)
   );

   pcore_execute pcore_execute_i (
      .clk               (clk),
      .rst_i             (rst_i),
      .id_valid_i        (id_valid),
      .id_pc_i           (id_pc),
      .id_rs1_data_i     (id_rs1_data),
      .id_rs2_data_i     (id_rs2_data),
      .id_imm_i          (id_imm),
      .id_rd_i           (id_rd),
      .id_alu_ops_i      (id_alu_ops),
      .id_br_ops_i       (id_br_ops),
      .id_opr1_sel_i     (id_opr1_sel),
      .id_opr2_sel_i     (id_opr2_sel),
      .id_cmp_opr2_sel_i (id_cmp_opr2_sel),
      .id_wb_sel_i       (id_wb_sel),
      .id_rd_wr_req_i    (id_rd_wr_req),
      .id_jump_req_i     (id_jump_req),
      .id_branch_req_i   (id_branch_req),
      .ex_fwd_valid_o    (ex_fwd_valid),
      .ex_fwd_rd_o       (ex_fwd_rd),
      .ex_fwd_data_o     (ex_fwd_data),
      .commit_valid_o    (commit_valid_o),
      .commit_pc_o       (commit_pc_o),
      .commit_we_o       (commit_we_o),
      .commit_rd_o       (commit_rd_o),
      .commit_result_o   (commit_result_o),
      .redirect_o        (redirect_o),
      .redirect_pc_o     (redirect_pc_o)
   );

endmodule : pcore_exe_top

//--- pcore_execute.sv
// Execute stage: ALU, branch compare, writeback select, forward path and commit register
`timescale 1ns/1ps

module pcore_execute (
   input  logic                     clk,
   input  logic                     rst_i,

   input  logic                     id_valid_i,
   input  pcore_pkg::xlen_t         id_pc_i,
   input  pcore_pkg::xlen_t         id_rs1_data_i,
   input  pcore_pkg::xlen_t         id_rs2_data_i,
   input  pcore_pkg::xlen_t         id_imm_i,
   input  pcore_pkg::reg_addr_t     id_rd_i,
   input  pcore_pkg::alu_ops_e      id_alu_ops_i,
   input  pcore_pkg::br_ops_e       id_br_ops_i,
   input  pcore_pkg::opr1_sel_e     id_opr1_sel_i,
   input  pcore_pkg::opr2_sel_e     id_opr2_sel_i,
   input  pcore_pkg::cmp_opr2_sel_e id_cmp_opr2_sel_i,
   input  pcore_pkg::wb_sel_e       id_wb_sel_i,
   input  logic                     id_rd_wr_req_i,
   input  logic                     id_jump_req_i,
   input  logic                     id_branch_req_i,

   output logic                     ex_fwd_valid_o,
   output pcore_pkg::reg_addr_t     ex_fwd_rd_o,
   output pcore_pkg::xlen_t         ex_fwd_data_o,

   output logic                     commit_valid_o,
   output pcore_pkg::xlen_t         commit_pc_o,
   output logic                     commit_we_o,
   output pcore_pkg::reg_addr_t     commit_rd_o,
   output pcore_pkg::xlen_t         commit_result_o,
   output logic                     redirect_o,
   output pcore_pkg::xlen_t         redirect_pc_o
);
   import pcore_pkg::*;

   xlen_t         opr1, opr2;
   xlen_t         adder_out;
   xlen_t         alu_result;
   xlen_t         rd_value;
   xlen_t         target;
   logic [4:0]    shamt;

   xlen_t         cmp_opr2;
   logic [XLEN:0] cmp_diff;          // Extra bit holds the borrow
   logic          cmp_eq;
   logic          cmp_neg;
   logic          cmp_ovf;
   logic          cmp_lt;
   logic          cond_met;
   logic          taken;
   logic          wr_req;

   assign opr1  = (id_opr1_sel_i == ALU_OPR1_PC)  ? id_pc_i  : id_rs1_data_i;
   assign opr2  = (id_opr2_sel_i == ALU_OPR2_IMM) ? id_imm_i : id_rs2_data_i;
   assign shamt = opr2[4:0];

   // Only SUB subtracts, branch targets and jumps add
   assign adder_out = (id_alu_ops_i == ALU_OPS_SUB) ? opr1 - opr2 : opr1 + opr2;

   assign cmp_opr2 = (id_cmp_opr2_sel_i == ALU_CMP_OPR2_IMM) ? id_imm_i : id_rs2_data_i;
   assign cmp_diff = {1'b0, id_rs1_data_i} - {1'b0, cmp_opr2};
   assign cmp_eq   = ~|cmp_diff[XLEN-1:0];
   assign cmp_neg  = cmp_diff[XLEN-1];
   assign cmp_ovf  = (cmp_neg & ~id_rs1_data_i[XLEN-1] & cmp_opr2[XLEN-1]) |
                     (~cmp_neg & id_rs1_data_i[XLEN-1] & ~cmp_opr2[XLEN-1]);
   assign cmp_lt   = cmp_neg ^ cmp_ovf;   // Signed less-than

   always_comb begin
      case (id_br_ops_i)
         BR_EQ:   cond_met = cmp_eq;
         BR_NE:   cond_met = ~cmp_eq;
         BR_LT:   cond_met = cmp_lt;
         BR_GE:   cond_met = ~cmp_lt;
         BR_LTU:  cond_met = cmp_diff[XLEN];
         BR_GEU:  cond_met = ~cmp_diff[XLEN];
         default: cond_met = 1'b0;
      endcase
   end

   always_comb begin
      case (id_alu_ops_i)
         ALU_OPS_ADD,
         ALU_OPS_SUB,
         ALU_OPS_BRANCH:    alu_result = adder_out;
         ALU_OPS_AND:       alu_result = opr1 & opr2;
         ALU_OPS_OR:        alu_result = opr1 | opr2;
         ALU_OPS_XOR:       alu_result = opr1 ^ opr2;
         ALU_OPS_SLL:       alu_result = opr1 << shamt;
         ALU_OPS_SRL:       alu_result = opr1 >> shamt;
         ALU_OPS_SRA:       alu_result = xlen_t'($signed(opr1) >>> shamt);
         ALU_OPS_SLT:       alu_result = xlen_t'(cmp_lt);
         ALU_OPS_SLTU:      alu_result = xlen_t'(cmp_diff[XLEN]);
         ALU_OPS_COPY_OPR2: alu_result = opr2;
         default:           alu_result = '0;
      endcase
   end

   assign rd_value = (id_wb_sel_i == RD_WB_PC_NEXT) ? id_pc_i + xlen_t'(4) : alu_result;
   assign taken    = id_valid_i & (id_jump_req_i | (id_branch_req_i & cond_met));

   // JALR is the only jump with a register base
   assign target = (id_jump_req_i && id_opr1_sel_i == ALU_OPR1_REG)
                 ? {adder_out[XLEN-1:1], 1'b0} : adder_out;

   assign wr_req         = id_valid_i & id_rd_wr_req_i & (id_rd_i != '0);
   assign ex_fwd_valid_o = wr_req;
   assign ex_fwd_rd_o    = id_rd_i;
   assign ex_fwd_data_o  = rd_value;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         commit_valid_o <= 1'b0;
         commit_we_o    <= 1'b0;
         redirect_o     <= 1'b0;
      end else begin
         commit_valid_o <= id_valid_i;
         commit_we_o    <= wr_req;
         redirect_o     <= taken;
      end
   end

   always_ff @(posedge clk) begin
      commit_pc_o     <= id_pc_i;
      commit_rd_o     <= id_rd_i;
      commit_result_o <= rd_value;
      redirect_pc_o   <= target;
   end

endmodule : pcore_execute

//--- pcore_pkg.sv
// Shared widths, vector types, operation encodings and RV32I opcodes for the core slice
package pcore_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       xlen_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [31:0]           instr_t;

   // ALU operation select
   typedef enum logic [3:0] {
      ALU_OPS_ADD,
      ALU_OPS_SUB,
      ALU_OPS_AND,
      ALU_OPS_OR,
      ALU_OPS_XOR,
      ALU_OPS_SLL,
      ALU_OPS_SRL,
      ALU_OPS_SRA,
      ALU_OPS_SLT,
      ALU_OPS_SLTU,
      ALU_OPS_COPY_OPR2,          // LUI passes the immediate through
      ALU_OPS_BRANCH,             // Adder computes the branch target
      ALU_OPS_NONE
   } alu_ops_e;

   // Branch condition
   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE,
      BR_LTU,
      BR_GEU
   } br_ops_e;

   typedef enum logic {
      ALU_OPR1_REG,
      ALU_OPR1_PC
   } opr1_sel_e;

   typedef enum logic {
      ALU_OPR2_REG,
      ALU_OPR2_IMM
   } opr2_sel_e;

   typedef enum logic {
      ALU_CMP_OPR2_REG,
      ALU_CMP_OPR2_IMM
   } cmp_opr2_sel_e;

   typedef enum logic {
      RD_WB_ALU,
      RD_WB_PC_NEXT               // Link address for jumps
   } wb_sel_e;

   // Major opcodes handled by this slice
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage : pcore_pkg

//--- pcore_regfile.sv
// Integer register file with 31 writable registers, two reads and write-first bypass
`timescale 1ns/1ps

module pcore_regfile (
   input  logic                 clk,
   input  logic                 rst_i,
   input  pcore_pkg::reg_addr_t rs1_addr_i,
   input  pcore_pkg::reg_addr_t rs2_addr_i,
   output pcore_pkg::xlen_t     rs1_rdata_o,
   output pcore_pkg::xlen_t     rs2_rdata_o,
   input  logic                 wr_en_i,
   input  pcore_pkg::reg_addr_t wr_addr_i,
   input  pcore_pkg::xlen_t     wr_data_i
);
   import pcore_pkg::*;

   xlen_t regs [1:31];   // x0 has no storage

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en_i && wr_addr_i != '0) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // Same-cycle write wins over the stored value
   assign rs1_rdata_o = (rs1_addr_i == '0) ? '0 :
                        (wr_en_i && wr_addr_i == rs1_addr_i) ? wr_data_i : regs[rs1_addr_i];
   assign rs2_rdata_o = (rs2_addr_i == '0) ? '0 :
                        (wr_en_i && wr_addr_i == rs2_addr_i) ? wr_data_i : regs[rs2_addr_i];

endmodule : pcore_regfile

//--- pcore_stim.txt
# valid instr pc | expected commit_valid we rd result redirect redirect_pc illegal, all in hex
# ALU register and immediate operations, LUI, AUIPC and forwarding at distances 1 to 3
1 FFB00093 00000100 1 1 01 FFFFFFFB 0 00000000 0
1 00700113 00000104 1 1 02 00000007 0 00000000 0
1 002081B3 00000108 1 1 03 00000002 0 00000000 0
1 40208233 0000010C 1 1 04 FFFFFFF4 0 00000000 0
1 0020F2B3 00000110 1 1 05 00000003 0 00000000 0
1 0020E333 00000114 1 1 06 FFFFFFFF 0 00000000 0
1 0020C3B3 00000118 1 1 07 FFFFFFFC 0 00000000 0
1 00111433 0000011C 1 1 08 38000000 0 00000000 0
1 0020D4B3 00000120 1 1 09 01FFFFFF 0 00000000 0
1 4020D533 00000124 1 1 0A FFFFFFFF 0 00000000 0
1 0020A5B3 00000128 1 1 0B 00000001 0 00000000 0
1 0020B633 0000012C 1 1 0C 00000000 0 00000000 0
1 FFC0A693 00000130 1 1 0D 00000001 0 00000000 0
1 FFF13713 00000134 1 1 0E 00000001 0 00000000 0
1 4010D793 00000138 1 1 0F FFFFFFFD 0 00000000 0
1 00411813 0000013C 1 1 10 00000070 0 00000000 0
1 01C0D893 00000140 1 1 11 0000000F 0 00000000 0
1 0F014913 00000144 1 1 12 000000F7 0 00000000 0
1 FF016993 00000148 1 1 13 FFFFFFF7 0 00000000 0
1 0FF0FA13 0000014C 1 1 14 000000FB 0 00000000 0
1 80000AB7 00000150 1 1 15 80000000 0 00000000 0
1 FFFA8B13 00000154 1 1 16 7FFFFFFF 0 00000000 0
1 016AABB3 00000158 1 1 17 00000001 0 00000000 0
1 016ABC33 0000015C 1 1 18 00000000 0 00000000 0
1 12345C97 00000160 1 1 19 12345160 0 00000000 0
0 00000000 00000000 0 0 00 00000000 0 00000000 0
# Branches taken and not taken, each taken one squashes the following slot
1 00210863 00000164 1 0 00 00000000 1 00000174 0
1 00100D13 00000168 0 0 00 00000000 0 00000000 0
1 00211863 00000174 1 0 00 00000000 0 00000000 0
1 001D0D13 00000178 1 1 1A 00000001 0 00000000 0
1 00208863 0000017C 1 0 00 00000000 0 00000000 0
1 00209863 00000180 1 0 00 00000000 1 00000190 0
1 001D0D13 00000184 0 0 00 00000000 0 00000000 0
1 FE20CCE3 00000190 1 0 00 00000000 1 00000188 0
1 001D0D13 00000194 0 0 00 00000000 0 00000000 0
1 00114863 00000188 1 0 00 00000000 0 00000000 0
1 0020D863 0000018C 1 0 00 00000000 0 00000000 0
1 00115863 00000190 1 0 00 00000000 1 000001A0 0
1 001D0D13 00000194 0 0 00 00000000 0 00000000 0
1 0020E863 000001A0 1 0 00 00000000 0 00000000 0
1 00116863 000001A4 1 0 00 00000000 1 000001B4 0
1 001D0D13 000001A8 0 0 00 00000000 0 00000000 0
1 00117863 000001B4 1 0 00 00000000 0 00000000 0
1 0020F863 000001B8 1 0 00 00000000 1 000001C8 0
1 001D0D13 000001BC 0 0 00 00000000 0 00000000 0
1 001D0D13 000001C8 1 1 1A 00000002 0 00000000 0
# JAL, JALR, writes to x0 and an unsupported opcode
1 01000E6F 000001CC 1 1 1C 000001D0 1 000001DC 0
1 001D0D13 000001D0 0 0 00 00000000 0 00000000 0
1 005E0EE7 000001DC 1 1 1D 000001E0 1 000001D4 0
1 001D0D13 000001E0 0 0 00 00000000 0 00000000 0
1 00510013 000001D4 1 0 00 00000000 0 00000000 0
1 00200DB3 000001D8 1 1 1B 00000007 0 00000000 0
1 00012083 000001DC 0 0 00 00000000 0 00000000 1
1 00008F33 000001E0 1 1 1E FFFFFFFB 0 00000000 0

//--- tb_pcore_exe.sv
// Testbench for the RV32I decode, execute and writeback slice, driven from a stimulus file
`timescale 1ns/1ps

module tb_pcore_exe;
   import pcore_pkg::*;

   localparam int    MAX_SLOTS    = 128;
   localparam int    CLK_PERIOD   = 100;
   localparam int    RESET_CYCLES = 8;
   localparam int    DRIVE_DELAY  = 10;
   localparam string STIM_FILE    = "pcore_stim.txt";

   logic      clk;
   logic      rst_i;
   logic      instr_valid_i;
   instr_t    instr_i;
   xlen_t     pc_i;
   logic      commit_valid_o;
   xlen_t     commit_pc_o;
   logic      commit_we_o;
   reg_addr_t commit_rd_o;
   xlen_t     commit_result_o;
   logic      redirect_o;
   xlen_t     redirect_pc_o;
   logic      illegal_o;

   // One entry per slot in the column order of the stimulus file
   logic      slot_valid      [MAX_SLOTS];
   instr_t    slot_instr      [MAX_SLOTS];
   xlen_t     slot_pc         [MAX_SLOTS];
   logic      exp_valid       [MAX_SLOTS];
   logic      exp_we          [MAX_SLOTS];
   reg_addr_t exp_rd          [MAX_SLOTS];
   xlen_t     exp_result      [MAX_SLOTS];
   logic      exp_redirect    [MAX_SLOTS];
   xlen_t     exp_redirect_pc [MAX_SLOTS];
   logic      exp_illegal     [MAX_SLOTS];

   int        num_slots;
   int        error_count;
   int        assert_errors;
   bit        stim_loaded = 1'b0;

   pcore_exe_top pcore_exe_top_i (
      .clk             (clk),
      .rst_i           (rst_i),
      .instr_valid_i   (instr_valid_i),
      .instr_i         (instr_i),
      .pc_i            (pc_i),
      .commit_valid_o  (commit_valid_o),
      .commit_pc_o     (commit_pc_o),
      .commit_we_o     (commit_we_o),
      .commit_rd_o     (commit_rd_o),
      .commit_result_o (commit_result_o),
      .redirect_o      (redirect_o),
      .redirect_pc_o   (redirect_pc_o),
      .illegal_o       (illegal_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(input string name, input int slot, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] slot %0d %s expected 0x%08h got 0x%08h", slot, name, expected, actual);
      end
   endtask

   // Comment lines and blank lines hold fewer than ten fields and are skipped
   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] fields [10];
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file %s", STIM_FILE);
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fields[0], fields[1], fields[2],
                     fields[3], fields[4], fields[5], fields[6], fields[7], fields[8],
                     fields[9]);
         if (n == 10 && num_slots < MAX_SLOTS) begin
            slot_valid[num_slots]      = fields[0][0];
            slot_instr[num_slots]      = fields[1];
            slot_pc[num_slots]         = fields[2];
            exp_valid[num_slots]       = fields[3][0];
            exp_we[num_slots]          = fields[4][0];
            exp_rd[num_slots]          = fields[5][4:0];
            exp_result[num_slots]      = fields[6];
            exp_redirect[num_slots]    = fields[7][0];
            exp_redirect_pc[num_slots] = fields[8];
            exp_illegal[num_slots]     = fields[9][0];
            num_slots++;
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_slot(input int idx);
      if (idx < num_slots) begin
         instr_valid_i = slot_valid[idx];
         instr_i       = slot_instr[idx];
         pc_i          = slot_pc[idx];
      end else begin
         instr_valid_i = 1'b0;        // Drain the pipeline with idle slots
         instr_i       = '0;
         pc_i          = '0;
      end
   endtask

   // Data fields only matter where the slot commits, writes or redirects
   task automatic check_slot(input int idx);
      check_value("commit_valid_o", idx, exp_valid[idx], commit_valid_o);
      check_value("commit_we_o", idx, exp_we[idx], commit_we_o);
      check_value("redirect_o", idx, exp_redirect[idx], redirect_o);
      check_value("illegal_o", idx, exp_illegal[idx], illegal_o);
      if (exp_valid[idx])
         check_value("commit_pc_o", idx, slot_pc[idx], commit_pc_o);
      if (exp_we[idx]) begin
         check_value("commit_rd_o", idx, exp_rd[idx], commit_rd_o);
         check_value("commit_result_o", idx, exp_result[idx], commit_result_o);
      end
      if (exp_redirect[idx])
         check_value("redirect_pc_o", idx, exp_redirect_pc[idx], redirect_pc_o);
   endtask

   initial begin
      rst_i         = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      pc_i          = '0;
      num_slots     = 0;
      error_count   = 0;
      assert_errors = 0;
      load_stimulus();
      if (num_slots == 0) begin
         $display("No stimulus slots were read from %s", STIM_FILE);
         error_count++;
      end
      stim_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_i = 1'b0;
      // Commit outputs of a slot are valid two edges after it is driven
      for (int i = 0; i < num_slots + 2; i++) begin
         if (i >= 2)
            check_slot(i - 2);
         drive_slot(i);
         @(posedge clk);
         #DRIVE_DELAY;
      end
      assert_errors = pcore_exe_top_i.pcore_exe_checker_i.fail_count;
      $display("Checked %0d slots with %0d mismatches and %0d assertion failures",
               num_slots, error_count, assert_errors);
      if (error_count == 0 && assert_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog sized from the number of slots in the file
   initial begin
      wait (stim_loaded);
      #((num_slots + 20) * CLK_PERIOD);
      $display("Timeout, the run did not finish within %0d ns", (num_slots + 20) * CLK_PERIOD);
      $display("TEST FAILED");
      $finish;
   end

endmodule : tb_pcore_exe
